//--- verilog/l2_mem_pkg.sv
// ****************************************
// sizes, bank counts and field types of the L2 local memory
// import into any module that stores or moves these fields
// ****************************************

package l2_mem_pkg;

    // cache geometry
    localparam int L2_WAYS       = 4;
    localparam int L2_WAY_BITS   = 2;
    localparam int L2_SET_BITS   = 6;
    localparam int L2_TAG_BITS   = 12;
    localparam int L2_LINE_BITS  = 128;
    localparam int L2_STATE_BITS = 3;

    // banks per field, selected by the upper set bits
    localparam int L2_LINE_BANKS  = 2;
    localparam int L2_TAG_BANKS   = 1;
    localparam int L2_STATE_BANKS = 1;
    localparam int L2_HPROT_BANKS = 1;
    localparam int L2_EVICT_BANKS = 1;

    typedef logic [L2_SET_BITS-1:0]   l2_set_t;
    typedef logic [L2_WAY_BITS-1:0]   l2_way_t;
    typedef logic [L2_TAG_BITS-1:0]   l2_tag_t;
    typedef logic [L2_LINE_BITS-1:0]  line_t;
    typedef logic [L2_STATE_BITS-1:0] state_t;

    // single protection bit per way
    typedef logic hprot_t;

endpackage

//--- verilog/l2_sram_bank.sv
// ****************************************
// behavioral synchronous RAM bank with a registered read port
// ****************************************

`timescale 1ns/10ps

module l2_sram_bank #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 64
) (
    input  logic                     clk,
    input  logic                     ce,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  payload_t                 wdata,
    output payload_t                 rdata
);

    payload_t mem [DEPTH];

    // read sees the old word when a write hits the same address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        if (ce) begin
            rdata <= mem[addr];
        end
    end

    // output register holds its value while ce is low
    a_addr_known: assert property (
        @(posedge clk) (ce || we) |-> !$isunknown(addr)
    ) else $error("sram bank: unknown address on an active access");

endmodule

//--- verilog/l2_field_array.sv
// ****************************************
// banked storage of one field for one way
// upper set bits pick the bank, the rest address inside it
// ****************************************

`timescale 1ns/10ps

module l2_field_array #(
    parameter type payload_t = logic,
    parameter int  NUM_BANKS = 1
) (
    input  logic                clk,
    input  logic                wr_rst,
    input  logic                rd_en,
    input  logic                we,
    input  l2_mem_pkg::l2_set_t set_in,
    input  payload_t            wdata,
    output payload_t            rdata
);

    import l2_mem_pkg::*;

    localparam int BANK_BITS = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 0;
    localparam int SEL_BITS  = (NUM_BANKS > 1) ? BANK_BITS : 1;
    localparam int ADDR_BITS = L2_SET_BITS - BANK_BITS;
    localparam int DEPTH     = 1 << ADDR_BITS;

    logic [SEL_BITS-1:0]  cur_bank;
    logic [SEL_BITS-1:0]  rd_bank;
    logic [ADDR_BITS-1:0] bank_addr;
    logic [NUM_BANKS-1:0] bank_we;
    logic [NUM_BANKS-1:0] bank_ce;
    payload_t             bank_rdata [NUM_BANKS];

    // a single bank shifts out every set bit and lands on bank 0
    assign cur_bank  = SEL_BITS'(set_in >> ADDR_BITS);
    assign bank_addr = set_in[ADDR_BITS-1:0];

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_we[b] = we && (cur_bank == SEL_BITS'(b));
            bank_ce[b] = rd_en && (cur_bank == SEL_BITS'(b));
        end
    end

    // remember which bank was read so the mux follows the read, not set_in
    always_ff @(posedge clk) begin
        if (wr_rst) begin
            rd_bank <= '0;
        end else if (rd_en) begin
            rd_bank <= cur_bank;
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        l2_sram_bank #(
            .payload_t (payload_t),
            .DEPTH     (DEPTH)
        ) u_bank (
            .clk   (clk),
            .ce    (bank_ce[b]),
            .we    (bank_we[b]),
            .addr  (bank_addr),
            .wdata (wdata),
            .rdata (bank_rdata[b])
        );
    end

    assign rdata = bank_rdata[rd_bank];

    // a write must land in exactly one existing bank
    a_one_bank_we: assert property (
        @(posedge clk) we |-> $onehot(bank_we)
    ) else $error("field array: write does not hit exactly one bank");

endmodule

//--- verilog/l2_way_store.sv
// ****************************************
// line, tag, state and hprot storage of one cache way
// ****************************************

`timescale 1ns/10ps

module l2_way_store (
    input  logic                clk,
    input  logic                wr_rst,
    input  logic                rd_en,
    input  l2_mem_pkg::l2_set_t set_in,
    input  logic                line_we,
    input  logic                tag_we,
    input  logic                state_we,
    input  logic                hprot_we,
    input  l2_mem_pkg::line_t   wr_data_line,
    input  l2_mem_pkg::l2_tag_t wr_data_tag,
    input  l2_mem_pkg::state_t  wr_data_state,
    input  l2_mem_pkg::hprot_t  wr_data_hprot,
    output l2_mem_pkg::line_t   rd_data_line,
    output l2_mem_pkg::l2_tag_t rd_data_tag,
    output l2_mem_pkg::state_t  rd_data_state,
    output l2_mem_pkg::hprot_t  rd_data_hprot
);

    import l2_mem_pkg::*;

    l2_field_array #(
        .payload_t (line_t),
        .NUM_BANKS (L2_LINE_BANKS)
    ) u_line (
        .clk    (clk),
        .wr_rst (wr_rst),
        .rd_en  (rd_en),
        .we     (line_we),
        .set_in (set_in),
        .wdata  (wr_data_line),
        .rdata  (rd_data_line)
    );

    l2_field_array #(
        .payload_t (l2_tag_t),
        .NUM_BANKS (L2_TAG_BANKS)
    ) u_tag (
        .clk    (clk),
        .wr_rst (wr_rst),
        .rd_en  (rd_en),
        .we     (tag_we),
        .set_in (set_in),
        .wdata  (wr_data_tag),
        .rdata  (rd_data_tag)
    );

    l2_field_array #(
        .payload_t (state_t),
        .NUM_BANKS (L2_STATE_BANKS)
    ) u_state (
        .clk    (clk),
        .wr_rst (wr_rst),
        .rd_en  (rd_en),
        .we     (state_we),
        .set_in (set_in),
        .wdata  (wr_data_state),
        .rdata  (rd_data_state)
    );

    l2_field_array #(
        .payload_t (hprot_t),
        .NUM_BANKS (L2_HPROT_BANKS)
    ) u_hprot (
        .clk    (clk),
        .wr_rst (wr_rst),
        .rd_en  (rd_en),
        .we     (hprot_we),
        .set_in (set_in),
        .wdata  (wr_data_hprot),
        .rdata  (rd_data_hprot)
    );

endmodule

//--- verilog/l2_write_ctrl.sv
// ****************************************
// per-way, per-field write enables from the way number and strobes
// ****************************************

`timescale 1ns/10ps

module l2_write_ctrl (
    input  l2_mem_pkg::l2_way_t              way,
    input  logic                             wr_en_line,
    input  logic                             wr_en_state,
    input  logic                             wr_en_state_all_ways,
    input  logic                             wr_en_put_reqs,
    output logic [l2_mem_pkg::L2_WAYS-1:0]   line_we,
    output logic [l2_mem_pkg::L2_WAYS-1:0]   tag_we,
    output logic [l2_mem_pkg::L2_WAYS-1:0]   state_we,
    output logic [l2_mem_pkg::L2_WAYS-1:0]   hprot_we
);

    import l2_mem_pkg::*;

    logic [L2_WAYS-1:0] way_sel;

    always_comb begin
        for (int i = 0; i < L2_WAYS; i++) begin
            way_sel[i] = (way == L2_WAY_BITS'(i));
        end
    end

    // a put request fills the whole entry of the selected way
    always_comb begin
        for (int i = 0; i < L2_WAYS; i++) begin
            line_we[i]  = way_sel[i] && (wr_en_line || wr_en_put_reqs);
            tag_we[i]   = way_sel[i] && wr_en_put_reqs;
            hprot_we[i] = way_sel[i] && wr_en_put_reqs;
            state_we[i] = (way_sel[i] && (wr_en_state || wr_en_put_reqs))
                          || wr_en_state_all_ways;
        end
    end

    // the all-ways state write would otherwise clobber the other ways' state
    always_comb begin
        a_all_ways_alone: assert final (
            (wr_en_state_all_ways && (wr_en_line || wr_en_put_reqs)) !== 1'b1
        ) else $error("write ctrl: all-ways state write mixed with line write");
    end

endmodule

//--- verilog/l2_localmem.sv
// ****************************************
// L2 local memory top, all ways of a set read in one access
// drive set_in and way with the strobes, read data follows 1 cycle later
// ****************************************

`timescale 1ns/10ps

module l2_localmem (
    input  logic                clk,
    input  logic                wr_rst,
    input  logic                rd_en,
    input  logic                wr_en_line,
    input  logic                wr_en_state,
    input  logic                wr_en_state_all_ways,
    input  logic                wr_en_put_reqs,
    input  logic                wr_en_evict_way,
    input  l2_mem_pkg::l2_set_t set_in,
    input  l2_mem_pkg::l2_way_t way,
    input  l2_mem_pkg::line_t   wr_data_line,
    input  l2_mem_pkg::l2_tag_t wr_data_tag,
    input  l2_mem_pkg::state_t  wr_data_state,
    input  l2_mem_pkg::hprot_t  wr_data_hprot,
    input  l2_mem_pkg::l2_way_t wr_data_evict_way,
    output l2_mem_pkg::line_t   rd_data_line [l2_mem_pkg::L2_WAYS],
    output l2_mem_pkg::l2_tag_t rd_data_tag [l2_mem_pkg::L2_WAYS],
    output l2_mem_pkg::state_t  rd_data_state [l2_mem_pkg::L2_WAYS],
    output l2_mem_pkg::hprot_t  rd_data_hprot [l2_mem_pkg::L2_WAYS],
    output l2_mem_pkg::l2_way_t rd_data_evict_way
);

    import l2_mem_pkg::*;

    logic [L2_WAYS-1:0] line_we;
    logic [L2_WAYS-1:0] tag_we;
    logic [L2_WAYS-1:0] state_we;
    logic [L2_WAYS-1:0] hprot_we;

    l2_write_ctrl u_write_ctrl (
        .way                  (way),
        .wr_en_line           (wr_en_line),
        .wr_en_state          (wr_en_state),
        .wr_en_state_all_ways (wr_en_state_all_ways),
        .wr_en_put_reqs       (wr_en_put_reqs),
        .line_we              (line_we),
        .tag_we               (tag_we),
        .state_we             (state_we),
        .hprot_we             (hprot_we)
    );

    for (genvar i = 0; i < L2_WAYS; i++) begin : g_way
        l2_way_store u_way (
            .clk           (clk),
            .wr_rst        (wr_rst),
            .rd_en         (rd_en),
            .set_in        (set_in),
            .line_we       (line_we[i]),
            .tag_we        (tag_we[i]),
            .state_we      (state_we[i]),
            .hprot_we      (hprot_we[i]),
            .wr_data_line  (wr_data_line),
            .wr_data_tag   (wr_data_tag),
            .wr_data_state (wr_data_state),
            .wr_data_hprot (wr_data_hprot),
            .rd_data_line  (rd_data_line[i]),
            .rd_data_tag   (rd_data_tag[i]),
            .rd_data_state (rd_data_state[i]),
            .rd_data_hprot (rd_data_hprot[i])
        );
    end

    // one evict pointer per set, way input plays no part
    l2_field_array #(
        .payload_t (l2_way_t),
        .NUM_BANKS (L2_EVICT_BANKS)
    ) u_evict_way (
        .clk    (clk),
        .wr_rst (wr_rst),
        .rd_en  (rd_en),
        .we     (wr_en_evict_way),
        .set_in (set_in),
        .wdata  (wr_data_evict_way),
        .rdata  (rd_data_evict_way)
    );

endmodule

//--- dv/l2_localmem_vectors.svh
// ****************************************
// operation table for the L2 local memory testbench, included in its body
// ****************************************

`ifndef L2_LOCALMEM_VECTORS_SVH
`define L2_LOCALMEM_VECTORS_SVH

// one operation per cycle, line and tag data come from $urandom
typedef struct packed {
    logic [3:0] test;
    logic       rd;
    logic       wline;
    logic       wstate;
    logic       wall;
    logic       wput;
    logic       wevict;
    logic [5:0] set;
    logic [1:0] way;
    logic [2:0] state;
    logic       hprot;
    logic [1:0] evict;
} vec_t;

localparam int NUM_VECTORS = 29;

// columns: test, rd, wr line, wr state, wr state all ways, wr put, wr evict,
//          set, way, state, hprot, evict way
localparam vec_t VECTORS [NUM_VECTORS] = '{
    '{4'd1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 6'd10, 2'd0, 3'd1, 1'b1, 2'd0},
    '{4'd1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 6'd10, 2'd1, 3'd2, 1'b0, 2'd0},
    '{4'd1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 6'd10, 2'd2, 3'd3, 1'b1, 2'd0},
    '{4'd1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 6'd10, 2'd3, 3'd4, 1'b0, 2'd0},
    '{4'd1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd10, 2'd0, 3'd0, 1'b0, 2'd0},
    '{4'd1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 6'd10, 2'd2, 3'd0, 1'b0, 2'd0},
    '{4'd1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd10, 2'd0, 3'd0, 1'b0, 2'd0},
    // put request, then a state-only write to the same way
    '{4'd2, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 6'd20, 2'd1, 3'd5, 1'b1, 2'd0},
    '{4'd2, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd20, 2'd0, 3'd0, 1'b0, 2'd0},
    '{4'd2, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 6'd20, 2'd1, 3'd6, 1'b0, 2'd0},
    '{4'd2, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd20, 2'd0, 3'd0, 1'b0, 2'd0},
    '{4'd3, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 6'd10, 2'd1, 3'd7, 1'b0, 2'd0},
    '{4'd3, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd10, 2'd0, 3'd0, 1'b0, 2'd0},
    // evict pointer ignores way
    '{4'd4, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 6'd3,  2'd0, 3'd0, 1'b0, 2'd2},
    '{4'd4, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 6'd40, 2'd3, 3'd0, 1'b0, 2'd1},
    '{4'd4, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 6'd63, 2'd1, 3'd0, 1'b0, 2'd3},
    '{4'd4, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd3,  2'd0, 3'd0, 1'b0, 2'd0},
    '{4'd4, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd40, 2'd0, 3'd0, 1'b0, 2'd0},
    '{4'd4, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd63, 2'd0, 3'd0, 1'b0, 2'd0},
    // sets 5 and 37 sit in different line banks
    '{4'd5, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 6'd5,  2'd0, 3'd2, 1'b1, 2'd0},
    '{4'd5, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 6'd37, 2'd0, 3'd3, 1'b0, 2'd0},
    '{4'd5, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd5,  2'd0, 3'd0, 1'b0, 2'd0},
    '{4'd5, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd37, 2'd0, 3'd0, 1'b0, 2'd0},
    '{4'd5, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd5,  2'd0, 3'd0, 1'b0, 2'd0},
    // idle cycles park set_in on the other line bank while the outputs hold
    '{4'd6, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 6'd5,  2'd0, 3'd0, 1'b0, 2'd0},
    '{4'd6, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd37, 2'd0, 3'd0, 1'b0, 2'd0},
    '{4'd6, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd37, 2'd0, 3'd0, 1'b0, 2'd0},
    '{4'd6, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd5,  2'd0, 3'd0, 1'b0, 2'd0},
    '{4'd6, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0,  2'd0, 3'd0, 1'b0, 2'd0}
};

`endif

//--- dv/l2_localmem_tb.sv
// ****************************************
// table-driven testbench for the L2 local memory with a reference model
// ****************************************

`timescale 1ns/10ps

module l2_localmem_tb;

    import l2_mem_pkg::*;

    `include "l2_localmem_vectors.svh"

    localparam int NUM_SETS   = 1 << L2_SET_BITS;
    localparam int MAX_CYCLES = NUM_VECTORS * 4 + 50;

    logic    clk;
    logic    wr_rst;
    logic    rd_en;
    logic    wr_en_line;
    logic    wr_en_state;
    logic    wr_en_state_all_ways;
    logic    wr_en_put_reqs;
    logic    wr_en_evict_way;
    l2_set_t set_in;
    l2_way_t way;
    line_t   wr_data_line;
    l2_tag_t wr_data_tag;
    state_t  wr_data_state;
    hprot_t  wr_data_hprot;
    l2_way_t wr_data_evict_way;
    line_t   rd_data_line [L2_WAYS];
    l2_tag_t rd_data_tag [L2_WAYS];
    state_t  rd_data_state [L2_WAYS];
    hprot_t  rd_data_hprot [L2_WAYS];
    l2_way_t rd_data_evict_way;

    // reference model, known flags mark entries that were written
    line_t   model_line [NUM_SETS][L2_WAYS];
    l2_tag_t model_tag [NUM_SETS][L2_WAYS];
    state_t  model_state [NUM_SETS][L2_WAYS];
    hprot_t  model_hprot [NUM_SETS][L2_WAYS];
    l2_way_t model_evict [NUM_SETS];
    logic    line_known [NUM_SETS][L2_WAYS];
    logic    tag_known [NUM_SETS][L2_WAYS];
    logic    state_known [NUM_SETS][L2_WAYS];
    logic    evict_known [NUM_SETS];

    // contents the outputs should show, from the last sampled read
    line_t   exp_line [L2_WAYS];
    l2_tag_t exp_tag [L2_WAYS];
    state_t  exp_state [L2_WAYS];
    hprot_t  exp_hprot [L2_WAYS];
    l2_way_t exp_evict;
    logic    exp_line_known [L2_WAYS];
    logic    exp_tag_known [L2_WAYS];
    logic    exp_state_known [L2_WAYS];
    logic    exp_evict_known;
    logic    shown_valid;

    int test_checks;
    int test_errors;
    int total_checks;
    int total_errors;

    l2_localmem dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic drive(input vec_t v, input line_t line, input l2_tag_t tag);
        rd_en                = v.rd;
        wr_en_line           = v.wline;
        wr_en_state          = v.wstate;
        wr_en_state_all_ways = v.wall;
        wr_en_put_reqs       = v.wput;
        wr_en_evict_way      = v.wevict;
        set_in               = v.set;
        way                  = v.way;
        wr_data_line         = line;
        wr_data_tag          = tag;
        wr_data_state        = v.state;
        wr_data_hprot        = v.hprot;
        wr_data_evict_way    = v.evict;
    endtask

    task automatic capture_expected(input int s);
        for (int w = 0; w < L2_WAYS; w++) begin
            exp_line[w]        = model_line[s][w];
            exp_tag[w]         = model_tag[s][w];
            exp_state[w]       = model_state[s][w];
            exp_hprot[w]       = model_hprot[s][w];
            exp_line_known[w]  = line_known[s][w];
            exp_tag_known[w]   = tag_known[s][w];
            exp_state_known[w] = state_known[s][w];
        end
        exp_evict       = model_evict[s];
        exp_evict_known = evict_known[s];
        shown_valid     = 1'b1;
    endtask

    task automatic apply_writes(input vec_t v, input line_t line, input l2_tag_t tag);
        int s;
        s = int'(v.set);
        if (v.wline || v.wput) begin
            model_line[s][v.way] = line;
            line_known[s][v.way] = 1'b1;
        end
        if (v.wput) begin
            model_tag[s][v.way]   = tag;
            model_hprot[s][v.way] = v.hprot;
            tag_known[s][v.way]   = 1'b1;
        end
        if (v.wstate || v.wput) begin
            model_state[s][v.way] = v.state;
            state_known[s][v.way] = 1'b1;
        end
        if (v.wall) begin
            for (int w = 0; w < L2_WAYS; w++) begin
                model_state[s][w] = v.state;
                state_known[s][w] = 1'b1;
            end
        end
        if (v.wevict) begin
            model_evict[s] = v.evict;
            evict_known[s] = 1'b1;
        end
    endtask

    task automatic check_value(input string name, input int idx, input logic [127:0] got,
                               input logic [127:0] exp, input logic known);
        if (known) begin
            test_checks++;
            assert (got === exp) else begin
                $display("mismatch %s[%0d]: got %h expected %h", name, idx, got, exp);
                test_errors++;
            end
        end
    endtask

    task automatic compare_outputs();
        for (int w = 0; w < L2_WAYS; w++) begin
            check_value("rd_data_line", w, rd_data_line[w], exp_line[w], exp_line_known[w]);
            check_value("rd_data_tag", w, rd_data_tag[w], exp_tag[w], exp_tag_known[w]);
            check_value("rd_data_state", w, rd_data_state[w], exp_state[w], exp_state_known[w]);
            check_value("rd_data_hprot", w, rd_data_hprot[w], exp_hprot[w], exp_tag_known[w]);
        end
        check_value("rd_data_evict_way", 0, rd_data_evict_way, exp_evict, exp_evict_known);
    endtask

    task automatic report_test(input int t);
        $display("test %0d: %0d checks, %0d mismatches, %s", t, test_checks, test_errors,
                 (test_errors == 0) ? "ok" : "failed");
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        vec_t    v;
        line_t   line;
        l2_tag_t tag;
        int      prev_test;
        void'($urandom(59990));
        drive('0, '0, '0);
        wr_rst       = 1'b1;
        shown_valid  = 1'b0;
        prev_test    = 0;
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            evict_known[s] = 1'b0;
            for (int w = 0; w < L2_WAYS; w++) begin
                line_known[s][w]  = 1'b0;
                tag_known[s][w]   = 1'b0;
                state_known[s][w] = 1'b0;
            end
        end
        repeat (4) @(posedge clk);
        #2;
        wr_rst = 1'b0;

        for (int i = 0; i < NUM_VECTORS; i++) begin
            @(posedge clk);
            #2;
            if (shown_valid) begin
                compare_outputs();
            end
            v = VECTORS[i];
            if (i > 0 && int'(v.test) != prev_test) begin
                report_test(prev_test);
            end
            line = {$urandom, $urandom, $urandom, $urandom};
            tag  = l2_tag_t'($urandom);
            drive(v, line, tag);
            // a read at the same edge as a write sees the old contents
            if (v.rd) begin
                capture_expected(int'(v.set));
            end
            apply_writes(v, line, tag);
            prev_test = int'(v.test);
        end
        @(posedge clk);
        #2;
        compare_outputs();
        report_test(prev_test);

        $display("checks %0d, mismatches %0d", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- src.f
+incdir+dv
verilog/l2_mem_pkg.sv
verilog/l2_sram_bank.sv
verilog/l2_field_array.sv
verilog/l2_way_store.sv
verilog/l2_write_ctrl.sv
verilog/l2_localmem.sv
dv/l2_localmem_tb.sv

//--- Bender.yml
package:
  name: l2_localmem

sources:
  - files:
      - verilog/l2_mem_pkg.sv
      - verilog/l2_sram_bank.sv
      - verilog/l2_field_array.sv
      - verilog/l2_way_store.sv
      - verilog/l2_write_ctrl.sv
      - verilog/l2_localmem.sv

  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/l2_localmem_tb.sv
